/* Bender.yml */
package:
  name: eth_mac_fifo

sources:
  - files:
      - source/eth_mac_pkg.sv
      - source/crc32_word.sv
      - source/frame_fifo.sv
      - source/eth_mac_tx.sv
      - source/eth_mac_rx.sv
      - source/eth_mac_fifo.sv
  - target: test
    files:
      - verification/eth_mac_fifo_tb.sv

/* eth_mac_fifo.f */
source/eth_mac_pkg.sv
source/crc32_word.sv
source/frame_fifo.sv
source/eth_mac_tx.sv
source/eth_mac_rx.sv
source/eth_mac_fifo.sv
verification/eth_mac_fifo_tb.sv

/* source/crc32_word.sv */
// CRC-32 word update, four bytes per step with the least significant byte first
`timescale 1ns/1ps
`default_nettype none

module crc32_word
    import eth_mac_pkg::*;
(
    input  word_t crc_in,
    input  word_t data,
    output word_t crc_out
);

    // Bit-serial form of the reflected CRC unrolled over 32 bits.
    // Bit 0 of data is the first bit on the wire (lane 0, bit 0).
    always_comb begin
        word_t crc;

        crc = crc_in;
        for (int i = 0; i < 32; i++) begin
            if (crc[0] ^ data[i]) begin
                crc = (crc >> 1) ^ CRC_POLY;
            end else begin
                crc = crc >> 1;
            end
        end
        crc_out = crc;
    end

endmodule

`default_nettype wire

/* source/eth_mac_fifo.sv */
// Ethernet MAC top level with transmit and receive frame FIFOs on one clock
`timescale 1ns/1ps
`default_nettype none

module eth_mac_fifo
    import eth_mac_pkg::*;
(
    input  logic         logic_clk,
    input  logic         logic_rst,

    // User transmit stream
    input  stream_word_t tx_axis,
    input  logic         tx_axis_valid,
    output logic         tx_axis_ready,

    // User receive stream
    output stream_word_t rx_axis,
    output logic         rx_axis_valid,
    input  logic         rx_axis_ready,

    // Line side
    input  xgmii_word_t  xgmii_rx,
    output xgmii_word_t  xgmii_tx,

    // Status
    output logic         tx_fifo_overflow,
    output logic         tx_fifo_bad_frame,
    output logic         tx_fifo_good_frame,
    output logic         rx_error_bad_fcs,
    output logic         rx_fifo_overflow,
    output logic         rx_fifo_bad_frame,
    output logic         rx_fifo_good_frame,

    // Configuration
    input  ifg_t         cfg_ifg,
    input  logic         cfg_tx_enable,
    input  logic         cfg_rx_enable
);

    stream_word_t tx_mac_axis;
    logic         tx_mac_axis_valid;
    logic         tx_mac_axis_ready;
    stream_word_t rx_mac_axis;
    logic         rx_mac_axis_valid;

    frame_fifo #(
        .DEPTH_LOG2 (TX_FIFO_DEPTH_LOG2)
    ) u_tx_fifo (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .in_word    (tx_axis),
        .in_valid   (tx_axis_valid),
        .in_ready   (tx_axis_ready),
        .out_word   (tx_mac_axis),
        .out_valid  (tx_mac_axis_valid),
        .out_ready  (tx_mac_axis_ready),
        .overflow   (tx_fifo_overflow),
        .bad_frame  (tx_fifo_bad_frame),
        .good_frame (tx_fifo_good_frame)
    );

    eth_mac_tx u_mac_tx (
        .logic_clk     (logic_clk),
        .logic_rst     (logic_rst),
        .in_word       (tx_mac_axis),
        .in_valid      (tx_mac_axis_valid),
        .in_ready      (tx_mac_axis_ready),
        .xgmii_tx      (xgmii_tx),
        .cfg_ifg       (cfg_ifg),
        .cfg_tx_enable (cfg_tx_enable)
    );

    eth_mac_rx u_mac_rx (
        .logic_clk     (logic_clk),
        .logic_rst     (logic_rst),
        .xgmii_rx      (xgmii_rx),
        .out_word      (rx_mac_axis),
        .out_valid     (rx_mac_axis_valid),
        .bad_fcs       (rx_error_bad_fcs),
        .cfg_rx_enable (cfg_rx_enable)
    );

    // MAC pushes without back-pressure, full memory drops the frame
    frame_fifo #(
        .DEPTH_LOG2 (RX_FIFO_DEPTH_LOG2)
    ) u_rx_fifo (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .in_word    (rx_mac_axis),
        .in_valid   (rx_mac_axis_valid),
        .in_ready   (),
        .out_word   (rx_axis),
        .out_valid  (rx_axis_valid),
        .out_ready  (rx_axis_ready),
        .overflow   (rx_fifo_overflow),
        .bad_frame  (rx_fifo_bad_frame),
        .good_frame (rx_fifo_good_frame)
    );

endmodule

`default_nettype wire

/* source/eth_mac_pkg.sv */
// Ethernet MAC shared types, XGMII control characters and FIFO sizes
`default_nettype none

package eth_mac_pkg;

    // Widths with a meaning of their own
    typedef logic [31:0] word_t;
    typedef logic [3:0]  lane_ctrl_t;
    typedef logic [7:0]  octet_t;
    typedef logic [7:0]  ifg_t;

    // One line-side word, lane 0 in the low byte
    typedef struct packed {
        word_t      d;
        lane_ctrl_t c;
    } xgmii_word_t;

    // One frame word on the user side and between blocks
    typedef struct packed {
        word_t data;
        logic  last;
        logic  bad;
    } stream_word_t;

    // XGMII control characters and preamble bytes
    localparam octet_t XGMII_IDLE    = 8'h07;
    localparam octet_t XGMII_START   = 8'hFB;
    localparam octet_t XGMII_TERM    = 8'hFD;
    localparam octet_t PREAMBLE_BYTE = 8'h55;
    localparam octet_t SFD_BYTE      = 8'hD5;

    // Reflected Ethernet CRC-32
    localparam word_t CRC_INIT = 32'hFFFFFFFF;
    localparam word_t CRC_POLY = 32'hEDB88320;

    localparam int TX_FIFO_DEPTH_LOG2 = 6;
    localparam int RX_FIFO_DEPTH_LOG2 = 6;

    // Fixed line words used by both MAC paths
    localparam xgmii_word_t XGMII_IDLE_WORD = '{d: {4{XGMII_IDLE}}, c: 4'hF};
    localparam xgmii_word_t XGMII_START_WORD =
        '{d: {{3{PREAMBLE_BYTE}}, XGMII_START}, c: 4'h1};
    localparam xgmii_word_t XGMII_PRE_WORD = '{d: {SFD_BYTE, {3{PREAMBLE_BYTE}}}, c: 4'h0};
    localparam xgmii_word_t XGMII_TERM_WORD = '{d: {{3{XGMII_IDLE}}, XGMII_TERM}, c: 4'hF};

endpackage

`default_nettype wire

/* source/eth_mac_rx.sv */
// Receive MAC that strips the XGMII framing, checks the FCS and flags bad frames
`timescale 1ns/1ps
`default_nettype none

module eth_mac_rx
    import eth_mac_pkg::*;
(
    input  logic         logic_clk,
    input  logic         logic_rst,
    input  xgmii_word_t  xgmii_rx,
    output stream_word_t out_word,
    output logic         out_valid,
    output logic         bad_fcs,
    input  logic         cfg_rx_enable
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PREAMBLE,
        RX_DATA
    } rx_state_t;

    rx_state_t state;

    // Two words stay back so the FCS and the last data word are known at terminate
    word_t held;
    word_t prev;
    logic  held_valid;
    logic  prev_valid;
    word_t crc;
    word_t crc_next;
    logic  is_data;
    logic  is_term;
    logic  shift;
    logic  finish;
    logic  fcs_ok;

    crc32_word u_crc (
        .crc_in  (crc),
        .data    (held),
        .crc_out (crc_next)
    );

    assign is_data = (xgmii_rx.c == '0);
    assign is_term = xgmii_rx.c[0] && (xgmii_rx.d[7:0] == XGMII_TERM);
    assign shift   = (state == RX_DATA) && is_data;
    // Any control word ends the frame, only a terminate can end it well
    assign finish  = (state == RX_DATA) && !is_data;
    assign fcs_ok  = (held == ~crc);

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state      <= RX_IDLE;
            held_valid <= 1'b0;
            prev_valid <= 1'b0;
            out_valid  <= 1'b0;
            bad_fcs    <= 1'b0;
        end else begin
            out_valid <= (shift || finish) && prev_valid;
            bad_fcs   <= finish && is_term && prev_valid && !fcs_ok;
            case (state)
                RX_IDLE: begin
                    if (cfg_rx_enable && xgmii_rx == XGMII_START_WORD) begin
                        state <= RX_PREAMBLE;
                    end
                end
                RX_PREAMBLE: begin
                    held_valid <= 1'b0;
                    prev_valid <= 1'b0;
                    // Malformed preamble or SFD drops back to idle
                    state <= (xgmii_rx == XGMII_PRE_WORD) ? RX_DATA : RX_IDLE;
                end
                RX_DATA: begin
                    if (shift) begin
                        held_valid <= 1'b1;
                        prev_valid <= held_valid;
                    end else begin
                        state <= RX_IDLE;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge logic_clk) begin
        if (state == RX_PREAMBLE) begin
            crc <= CRC_INIT;
        end else if (shift && held_valid) begin
            crc <= crc_next;
        end
        if (shift) begin
            held <= xgmii_rx.d;
            prev <= held;
        end
        if (shift || finish) begin
            out_word.data <= prev;
            out_word.last <= finish;
            out_word.bad  <= finish && !(is_term && fcs_ok);
        end
    end

endmodule

`default_nettype wire

/* source/eth_mac_tx.sv */
// Transmit MAC that frames stream words onto XGMII with preamble, FCS and inter-frame gap
`timescale 1ns/1ps
`default_nettype none

module eth_mac_tx
    import eth_mac_pkg::*;
(
    input  logic         logic_clk,
    input  logic         logic_rst,
    input  stream_word_t in_word,
    input  logic         in_valid,
    output logic         in_ready,
    output xgmii_word_t  xgmii_tx,
    input  ifg_t         cfg_ifg,
    input  logic         cfg_tx_enable
);

    // Each state names the line word driven at its closing edge
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_PREAMBLE,
        TX_DATA,
        TX_FCS,
        TX_TERM,
        TX_GAP
    } tx_state_t;

    tx_state_t state;
    ifg_t      gap_cnt;
    word_t     crc;
    word_t     crc_next;
    logic      gap_done;

    crc32_word u_crc (
        .crc_in  (crc),
        .data    (in_word.data),
        .crc_out (crc_next)
    );

    assign in_ready = (state == TX_DATA);

    // Widened compare so an ifg of 0 or 255 still ends the gap
    assign gap_done = ({1'b0, gap_cnt} + 9'd1) >= {1'b0, cfg_ifg};

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state    <= TX_IDLE;
            gap_cnt  <= '0;
            xgmii_tx <= XGMII_IDLE_WORD;
        end else begin
            case (state)
                TX_IDLE: begin
                    xgmii_tx <= XGMII_IDLE_WORD;
                    // Enable is only looked at between frames
                    if (cfg_tx_enable && in_valid) begin
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    xgmii_tx <= XGMII_START_WORD;
                    state    <= TX_PREAMBLE;
                end
                TX_PREAMBLE: begin
                    xgmii_tx <= XGMII_PRE_WORD;
                    state    <= TX_DATA;
                end
                TX_DATA: begin
                    // Committed frames stream back to back from the FIFO
                    if (in_valid) begin
                        xgmii_tx <= '{d: in_word.data, c: '0};
                        if (in_word.last) begin
                            state <= TX_FCS;
                        end
                    end else begin
                        xgmii_tx <= XGMII_IDLE_WORD;
                    end
                end
                TX_FCS: begin
                    xgmii_tx <= '{d: ~crc, c: '0};
                    state    <= TX_TERM;
                end
                TX_TERM: begin
                    xgmii_tx <= XGMII_TERM_WORD;
                    gap_cnt  <= '0;
                    state    <= TX_GAP;
                end
                TX_GAP: begin
                    xgmii_tx <= XGMII_IDLE_WORD;
                    gap_cnt  <= gap_cnt + 1'b1;
                    if (gap_done) begin
                        state <= TX_IDLE;
                    end
                end
                default: begin
                    xgmii_tx <= XGMII_IDLE_WORD;
                    state    <= TX_IDLE;
                end
            endcase
        end
    end

    // Running CRC over the data words of the current frame
    always_ff @(posedge logic_clk) begin
        if (state == TX_PREAMBLE) begin
            crc <= CRC_INIT;
        end else if (in_valid && in_ready) begin
            crc <= crc_next;
        end
    end

endmodule

`default_nettype wire

/* source/frame_fifo.sv */
// Store-and-forward frame FIFO that drops bad and oversized frames and reports each frame
`timescale 1ns/1ps
`default_nettype none

module frame_fifo
    import eth_mac_pkg::*;
#(
    parameter int DEPTH_LOG2 = 6
) (
    input  logic         logic_clk,
    input  logic         logic_rst,
    input  stream_word_t in_word,
    input  logic         in_valid,
    output logic         in_ready,
    output stream_word_t out_word,
    output logic         out_valid,
    input  logic         out_ready,
    output logic         overflow,
    output logic         bad_frame,
    output logic         good_frame
);

    // One extra pointer bit tells full from empty
    typedef logic [DEPTH_LOG2:0] ptr_t;

    stream_word_t mem [2**DEPTH_LOG2];

    ptr_t wr_ptr;
    ptr_t wr_ptr_next;
    ptr_t commit_ptr;
    ptr_t commit_ptr_next;
    ptr_t rd_ptr;
    ptr_t rd_ptr_next;
    logic drop_frame;
    logic drop_frame_next;
    logic full;
    logic push;
    logic mem_write;
    logic load_out;
    logic overflow_next;
    logic bad_frame_next;
    logic good_frame_next;

    assign full = (wr_ptr - rd_ptr) == {1'b1, {DEPTH_LOG2{1'b0}}};
    assign push = in_valid && in_ready;

    // Only committed words are read out
    assign load_out = (rd_ptr != commit_ptr) && (!out_valid || out_ready);
    assign rd_ptr_next = load_out ? rd_ptr + 1'b1 : rd_ptr;

    always_comb begin
        wr_ptr_next     = wr_ptr;
        commit_ptr_next = commit_ptr;
        drop_frame_next = drop_frame;
        mem_write       = 1'b0;
        overflow_next   = 1'b0;
        bad_frame_next  = 1'b0;
        good_frame_next = 1'b0;
        if (in_valid && full && !drop_frame) begin
            // Frame meets a full memory, discard the rest of it
            drop_frame_next = 1'b1;
        end else if (push) begin
            if (in_word.last) begin
                if (drop_frame) begin
                    wr_ptr_next     = commit_ptr;
                    drop_frame_next = 1'b0;
                    overflow_next   = 1'b1;
                end else if (in_word.bad) begin
                    wr_ptr_next    = commit_ptr;
                    bad_frame_next = 1'b1;
                end else begin
                    mem_write       = 1'b1;
                    wr_ptr_next     = wr_ptr + 1'b1;
                    commit_ptr_next = wr_ptr + 1'b1;
                    good_frame_next = 1'b1;
                end
            end else if (!drop_frame) begin
                mem_write   = 1'b1;
                wr_ptr_next = wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            drop_frame <= 1'b0;
            in_ready   <= 1'b0;
            out_valid  <= 1'b0;
            overflow   <= 1'b0;
            bad_frame  <= 1'b0;
            good_frame <= 1'b0;
        end else begin
            wr_ptr     <= wr_ptr_next;
            commit_ptr <= commit_ptr_next;
            rd_ptr     <= rd_ptr_next;
            drop_frame <= drop_frame_next;
            in_ready   <= ((wr_ptr_next - rd_ptr_next) != {1'b1, {DEPTH_LOG2{1'b0}}})
                          || drop_frame_next;
            if (load_out) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
            overflow   <= overflow_next;
            bad_frame  <= bad_frame_next;
            good_frame <= good_frame_next;
        end
    end

    always_ff @(posedge logic_clk) begin
        if (mem_write) begin
            mem[wr_ptr[DEPTH_LOG2-1:0]] <= in_word;
        end
        if (load_out) begin
            out_word <= mem[rd_ptr[DEPTH_LOG2-1:0]];
        end
    end

endmodule

`default_nettype wire

/* verification/eth_mac_fifo_tb.sv */
// Loopback testbench for the Ethernet MAC with frame FIFOs, checked against reference queues
`timescale 1ns/1ps
`default_nettype none

module eth_mac_fifo_tb
    import eth_mac_pkg::*;
;

    typedef enum {FRAME_GOOD, FRAME_TX_BAD, FRAME_LINE_ONLY} frame_kind_t;
    typedef enum {READY_HIGH, READY_RANDOM, READY_LOW} ready_mode_t;
    typedef enum {LINE_IDLE, LINE_PRE, LINE_DATA} line_state_t;

    // Status bit positions in status_bits
    localparam int TX_BAD  = 1;
    localparam int TX_GOOD = 2;
    localparam int RX_FCS  = 3;
    localparam int RX_OVF  = 4;
    localparam int RX_BAD  = 5;
    localparam int RX_GOOD = 6;
    localparam int TOTAL_FRAMES = 41;

    logic         logic_clk = 1'b0;
    logic         logic_rst;
    stream_word_t tx_axis;
    logic         tx_axis_valid;
    logic         tx_axis_ready;
    stream_word_t rx_axis;
    logic         rx_axis_valid;
    logic         rx_axis_ready = 1'b1;
    xgmii_word_t  xgmii_rx;
    xgmii_word_t  xgmii_tx;
    xgmii_word_t  corrupt_mask = '0;
    xgmii_word_t  prev_line = '0;
    wire  [6:0]   status_bits;
    ifg_t         cfg_ifg;
    logic         cfg_tx_enable;
    logic         cfg_rx_enable;

    integer       seed = 32'hce9b;
    // Separate stream for back-pressure
    integer       ready_seed = 32'hce9b ^ 32'h0000ffff;
    ready_mode_t  ready_mode;
    bit           throttle;
    int           corrupt_request;
    int           corrupt_served;
    int           expected [7];
    int           seen [7];
    int           line_expected;
    int           line_frames;
    int           start_count;
    int           idle_count;
    line_state_t  line_state;
    stream_word_t exp_q [$];
    stream_word_t line_q [$];
    word_t        line_buf [$];

    eth_mac_fifo u_dut (
        .logic_clk          (logic_clk),
        .logic_rst          (logic_rst),
        .tx_axis            (tx_axis),
        .tx_axis_valid      (tx_axis_valid),
        .tx_axis_ready      (tx_axis_ready),
        .rx_axis            (rx_axis),
        .rx_axis_valid      (rx_axis_valid),
        .rx_axis_ready      (rx_axis_ready),
        .xgmii_rx           (xgmii_rx),
        .xgmii_tx           (xgmii_tx),
        .tx_fifo_overflow   (status_bits[0]),
        .tx_fifo_bad_frame  (status_bits[TX_BAD]),
        .tx_fifo_good_frame (status_bits[TX_GOOD]),
        .rx_error_bad_fcs   (status_bits[RX_FCS]),
        .rx_fifo_overflow   (status_bits[RX_OVF]),
        .rx_fifo_bad_frame  (status_bits[RX_BAD]),
        .rx_fifo_good_frame (status_bits[RX_GOOD]),
        .cfg_ifg            (cfg_ifg),
        .cfg_tx_enable      (cfg_tx_enable),
        .cfg_rx_enable      (cfg_rx_enable)
    );

    // Line loopback, the mask flips bits of one word on demand
    assign xgmii_rx = xgmii_tx ^ corrupt_mask;

    always #5 logic_clk = ~logic_clk;

    task automatic stop_on_failure();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        $display("error: %0d ns: %s", $time, msg);
        stop_on_failure();
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        stop_on_failure();
    endtask

    function automatic string status_name(input int idx);
        case (idx)
            TX_BAD:  return "tx_fifo_bad_frame";
            TX_GOOD: return "tx_fifo_good_frame";
            RX_FCS:  return "rx_error_bad_fcs";
            RX_OVF:  return "rx_fifo_overflow";
            RX_BAD:  return "rx_fifo_bad_frame";
            RX_GOOD: return "rx_fifo_good_frame";
            default: return "tx_fifo_overflow";
        endcase
    endfunction

    // Ethernet CRC-32, one byte at a time, lane 0 first
    function automatic word_t fcs_update(input word_t crc, input word_t data);
        word_t c;
        int    k;
        int    j;
        c = crc;
        for (k = 0; k < 4; k++) begin
            c = c ^ {24'h0, data[8*k +: 8]};
            for (j = 0; j < 8; j++) begin
                c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
            end
        end
        return c;
    endfunction

    function automatic int random_len();
        return 2 + ({$random(seed)} % 15);
    endfunction

    // Data words plus the FCS of one frame seen on xgmii_tx
    task automatic check_line_frame();
        word_t        crc;
        stream_word_t ref_word;
        int           i;
        assert (line_buf.size() >= 2)
        else report_mismatch("frame on the line has no data word");
        crc = CRC_INIT;
        for (i = 0; i < line_buf.size() - 1; i++) begin
            assert (line_q.size() != 0)
            else abort_run("A frame appeared on the line that was never sent.");
            ref_word = line_q.pop_front();
            assert (line_buf[i] == ref_word.data && ref_word.last == (i == line_buf.size() - 2))
            else report_mismatch($sformatf("line word %0d is %h, expected %h last %0b",
                                           i, line_buf[i], ref_word.data, ref_word.last));
            crc = fcs_update(crc, ref_word.data);
        end
        assert (line_buf[line_buf.size() - 1] == ~crc)
        else report_mismatch($sformatf("FCS on the line is %h, expected %h",
                                       line_buf[line_buf.size() - 1], ~crc));
    endtask

    always @(posedge logic_clk) begin : line_check
        int gap_needed;
        gap_needed = (cfg_ifg > 8'd1) ? int'(cfg_ifg) : 1;
        if (logic_rst) begin
            line_state = LINE_IDLE;
            idle_count = 1000;
        end else begin
            case (line_state)
                LINE_IDLE: begin
                    if (xgmii_tx == XGMII_IDLE_WORD) begin
                        idle_count++;
                    end else begin
                        assert (xgmii_tx == XGMII_START_WORD)
                        else report_mismatch($sformatf("expected start word, got %h", xgmii_tx));
                        assert (idle_count >= gap_needed)
                        else report_mismatch($sformatf("gap of %0d idle words, at least %0d due",
                                                       idle_count, gap_needed));
                        start_count++;
                        line_state = LINE_PRE;
                    end
                end
                LINE_PRE: begin
                    assert (xgmii_tx == XGMII_PRE_WORD)
                    else report_mismatch($sformatf("expected preamble word, got %h", xgmii_tx));
                    line_buf.delete();
                    line_state = LINE_DATA;
                end
                default: begin
                    if (xgmii_tx.c == '0) begin
                        line_buf.push_back(xgmii_tx.d);
                    end else begin
                        assert (xgmii_tx == XGMII_TERM_WORD)
                        else report_mismatch($sformatf("expected terminate word, got %h",
                                                       xgmii_tx));
                        check_line_frame();
                        line_frames++;
                        idle_count = 0;
                        line_state = LINE_IDLE;
                    end
                end
            endcase
        end
    end

    always @(posedge logic_clk) begin : rx_check
        stream_word_t exp_word;
        if (!logic_rst && rx_axis_valid && rx_axis_ready) begin
            assert (exp_q.size() != 0)
            else abort_run("A word came out at rx_axis although no frame was expected.");
            exp_word = exp_q.pop_front();
            assert (rx_axis == exp_word)
            else report_mismatch($sformatf("rx_axis %h last %0b bad %0b, expected %h last %0b",
                                           rx_axis.data, rx_axis.last, rx_axis.bad,
                                           exp_word.data, exp_word.last));
        end
    end

    always @(posedge logic_clk) begin : status_count
        int i;
        if (logic_rst) begin
            assert (xgmii_tx == XGMII_IDLE_WORD && !rx_axis_valid && !tx_axis_ready
                    && status_bits == '0)
            else report_mismatch("outputs not in their reset state");
        end else begin
            for (i = 0; i < 7; i++) begin
                if (status_bits[i]) begin
                    seen[i]++;
                end
            end
        end
    end

    always @(negedge logic_clk) begin : ready_drive
        case (ready_mode)
            READY_RANDOM: rx_axis_ready <= ({$random(ready_seed)} % 4) != 0;
            READY_LOW:    rx_axis_ready <= 1'b0;
            default:      rx_axis_ready <= 1'b1;
        endcase
    end

    // Flip one bit in the first data word after a preamble word
    always @(negedge logic_clk) begin : corrupt_inject
        if (corrupt_request != corrupt_served && prev_line == XGMII_PRE_WORD
                && xgmii_tx.c == '0) begin
            corrupt_mask.d = 32'h0000_0100;
            corrupt_mask.c = '0;
            corrupt_served++;
        end else begin
            corrupt_mask = '0;
        end
        prev_line = xgmii_tx;
    end

    task automatic send_frame(input int len, input frame_kind_t kind);
        stream_word_t w;
        int           i;
        // At most two frames waiting for the line
        while (throttle && line_expected - line_frames >= 2) @(negedge logic_clk);
        for (i = 0; i < len; i++) begin
            w.data = $random(seed);
            w.last = (i == len - 1);
            w.bad  = (kind == FRAME_TX_BAD) && (i == len - 1);
            if (kind != FRAME_TX_BAD) begin
                line_q.push_back(w);
            end
            if (kind == FRAME_GOOD) begin
                exp_q.push_back(w);
            end
            tx_axis       = w;
            tx_axis_valid = 1'b1;
            @(posedge logic_clk);
            while (!tx_axis_ready) @(posedge logic_clk);
            @(negedge logic_clk);
            tx_axis_valid = 1'b0;
        end
        if (kind == FRAME_TX_BAD) begin
            expected[TX_BAD]++;
        end else begin
            expected[TX_GOOD]++;
            line_expected++;
        end
        if (kind == FRAME_GOOD) begin
            expected[RX_GOOD]++;
        end
    endtask

    task automatic wait_line();
        while (line_frames != line_expected) @(negedge logic_clk);
    endtask

    task automatic check_counts();
        int i;
        for (i = 0; i < 7; i++) begin
            assert (seen[i] == expected[i])
            else report_mismatch($sformatf("%s pulsed %0d times, expected %0d",
                                           status_name(i), seen[i], expected[i]));
        end
    endtask

    // Status pulses trail the last line word by two cycles
    task automatic finish_phase();
        wait_line();
        while (exp_q.size() != 0) @(negedge logic_clk);
        repeat (8) @(negedge logic_clk);
        check_counts();
    endtask

    initial begin : watchdog
        repeat (TOTAL_FRAMES * 40 + 2000) @(posedge logic_clk);
        abort_run("Timeout: the frames did not all come back in time.");
    end

    initial begin : stimulus
        int starts_before;
        logic_rst       = 1'b1;
        tx_axis         = '0;
        tx_axis_valid   = 1'b0;
        cfg_ifg         = 8'd3;
        cfg_tx_enable   = 1'b1;
        cfg_rx_enable   = 1'b1;
        ready_mode      = READY_HIGH;
        throttle        = 1'b1;
        corrupt_request = 0;
        repeat (16) @(negedge logic_clk);
        logic_rst = 1'b0;

        repeat (8) send_frame(random_len(), FRAME_GOOD);
        finish_phase();
        cfg_ifg = 8'd1;
        repeat (6) send_frame(random_len(), FRAME_GOOD);
        finish_phase();
        cfg_ifg = 8'd12;
        repeat (6) send_frame(random_len(), FRAME_GOOD);
        finish_phase();

        // Bad frame is dropped by the transmit FIFO
        send_frame(random_len(), FRAME_TX_BAD);
        send_frame(random_len(), FRAME_GOOD);
        finish_phase();

        // Corrupted frame fails its FCS, the next one passes
        corrupt_request++;
        send_frame(random_len(), FRAME_LINE_ONLY);
        expected[RX_FCS]++;
        expected[RX_BAD]++;
        send_frame(random_len(), FRAME_GOOD);
        finish_phase();

        ready_mode = READY_RANDOM;
        repeat (6) send_frame(random_len(), FRAME_GOOD);
        finish_phase();

        // Four 16-word frames fill the memory and output register, two more overflow
        ready_mode = READY_LOW;
        repeat (4) send_frame(16, FRAME_GOOD);
        repeat (2) send_frame(16, FRAME_LINE_ONLY);
        expected[RX_OVF] += 2;
        wait_line();
        repeat (8) @(negedge logic_clk);
        ready_mode = READY_HIGH;
        finish_phase();

        cfg_rx_enable = 1'b0;
        repeat (2) send_frame(random_len(), FRAME_LINE_ONLY);
        finish_phase();
        cfg_rx_enable = 1'b1;

        cfg_tx_enable = 1'b0;
        throttle      = 1'b0;
        starts_before = start_count;
        repeat (3) send_frame(random_len(), FRAME_GOOD);
        repeat (200) @(negedge logic_clk);
        assert (start_count == starts_before)
        else report_mismatch("frame started on the line with the transmitter disabled");
        cfg_tx_enable = 1'b1;
        throttle      = 1'b1;
        finish_phase();

        assert (line_q.size() == 0)
        else abort_run("Some frames were queued for the line but never sent.");
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
